//--- aluUnit.sv
`timescale 1ns/1ps
`default_nettype none

module aluUnit (
    input  wire                clock,
    input  wire                rstN,
    input  miniSrcPkg::wordT   busData,  // operand b.
    input  miniSrcPkg::opcodeT opcode,
    input  wire                Yin,      // latch operand a.
    input  wire                Zin,      // capture result.
    input  wire                IncPC,    // z gets bus plus one.
    output miniSrcPkg::wordT   zOut
);

    miniSrcPkg::wordT yReg;      // operand a.
    miniSrcPkg::wordT zReg;      // result register, low word only.
    miniSrcPkg::wordT aluResult;
    logic [miniSrcPkg::shamtWidth-1:0] shamt;

    assign shamt = busData[miniSrcPkg::shamtWidth-1:0]; // low five bits of b.

    always_ff @(posedge clock) begin
        if (!rstN) begin
            yReg <= '0;
        end else if (Yin) begin
            yReg <= busData;
        end
    end

    // a is y, b is the bus.
    always_comb begin
        case (opcode)
            miniSrcPkg::opAdd: aluResult = yReg + busData;
            miniSrcPkg::opSub: aluResult = yReg - busData;
            miniSrcPkg::opAnd: aluResult = yReg & busData;
            miniSrcPkg::opOr:  aluResult = yReg | busData;
            miniSrcPkg::opShr: aluResult = yReg >> shamt;  // zero fill.
            miniSrcPkg::opShl: aluResult = yReg << shamt;
            miniSrcPkg::opNeg: aluResult = -busData;       // unary, uses b only.
            miniSrcPkg::opNot: aluResult = ~busData;       // unary, uses b only.
            miniSrcPkg::opNop: aluResult = '0;
            default:           aluResult = '0;             // unused codes.
        endcase
    end

    always_ff @(posedge clock) begin
        if (!rstN) begin
            zReg <= '0;
        end else if (Zin) begin
            if (IncPC) begin
                zReg <= busData + 1'b1; // pc increment ignores opcode.
            end else begin
                zReg <= aluResult;
            end
        end
    end

    assign zOut = zReg;

endmodule

`default_nettype wire

//--- busArbiter.sv
`timescale 1ns/1ps
`default_nettype none

module busArbiter (
    input  miniSrcPkg::wordT regOut,       // selected register.
    input  miniSrcPkg::wordT pcOut,        // program counter.
    input  miniSrcPkg::wordT mdrOut,       // memory data register.
    input  miniSrcPkg::wordT zOut,         // alu result register.
    input  miniSrcPkg::wordT inPortOut,    // input port register.
    input  miniSrcPkg::wordT cOut,         // sign-extended constant.
    input  wire              Rout,
    input  wire              BAout,
    input  wire              PCout_en,
    input  wire              MDRout,
    input  wire              Zlowout,
    input  wire              inPortOut_en,
    input  wire              Cout,
    output miniSrcPkg::wordT busData       // the shared bus.
);

    logic [5:0] grant; // one-hot, bit 0 highest priority.

    always_comb begin
        grant = '0;
        if (Rout || BAout)    grant[0] = 1'b1; // register bank wins first.
        else if (PCout_en)    grant[1] = 1'b1;
        else if (MDRout)      grant[2] = 1'b1;
        else if (Zlowout)     grant[3] = 1'b1;
        else if (inPortOut_en) grant[4] = 1'b1;
        else if (Cout)        grant[5] = 1'b1; // constant is last.
    end

    // and-or mux, zero when nothing is granted.
    assign busData = ({miniSrcPkg::wordWidth{grant[0]}} & regOut)
                   | ({miniSrcPkg::wordWidth{grant[1]}} & pcOut)
                   | ({miniSrcPkg::wordWidth{grant[2]}} & mdrOut)
                   | ({miniSrcPkg::wordWidth{grant[3]}} & zOut)
                   | ({miniSrcPkg::wordWidth{grant[4]}} & inPortOut)
                   | ({miniSrcPkg::wordWidth{grant[5]}} & cOut);

endmodule

`default_nettype wire

//--- datapath_chk.sv
`timescale 1ns/1ps
`default_nettype none

module datapath_chk (
    input wire              clock,
    input wire              rstN,
    input miniSrcPkg::wordT busData,
    input miniSrcPkg::wordT pcOut,
    input wire              Rout,
    input wire              BAout,
    input wire              PCout_en,
    input wire              MDRout,
    input wire              Zlowout,
    input wire              inPortOut_en,
    input wire              Cout
);

    logic [6:0] outStrobes; // bit 4 is PCout_en.

    assign outStrobes = {Rout, BAout, PCout_en, MDRout, Zlowout, inPortOut_en, Cout};

    singleDriver: assert property (@(posedge clock) disable iff (!rstN)
        $onehot0(outStrobes))
        else $error("more than one out-strobe active: %b", outStrobes);

    // no request means an idle bus.
    idleBusZero: assert property (@(posedge clock) (outStrobes == '0) |-> (busData == '0))
        else $error("bus not zero while idle: %h", busData);

    pcOnBus: assert property (@(posedge clock) disable iff (!rstN)
        (outStrobes == 7'b0010000) |-> (busData == pcOut))
        else $error("bus %h differs from pc %h", busData, pcOut);

endmodule

`default_nettype wire

//--- ioPorts.sv
`timescale 1ns/1ps
`default_nettype none

module ioPorts (
    input  wire              clock,
    input  wire              rstN,
    input  miniSrcPkg::wordT busData,
    input  miniSrcPkg::wordT inPortDataIn, // external input pins.
    input  wire              inPort_en,    // sample external input.
    input  wire              outPort_en,   // load output from bus.
    output miniSrcPkg::wordT inPortOut,
    output miniSrcPkg::wordT outPortData   // registered, zero after reset.
);

    miniSrcPkg::wordT inReg;
    miniSrcPkg::wordT outReg;

    always_ff @(posedge clock) begin
        if (!rstN) begin
            inReg  <= '0;
            outReg <= '0;
        end else begin
            if (inPort_en) inReg <= inPortDataIn; // outside world in.
            if (outPort_en) outReg <= busData;    // bus out.
        end
    end

    assign inPortOut   = inReg;
    assign outPortData = outReg;

endmodule

`default_nettype wire

//--- memoryInterface.sv
`timescale 1ns/1ps
`default_nettype none

module memoryInterface (
    input  wire              clock,
    input  wire              rstN,
    input  miniSrcPkg::wordT busData,
    input  wire              MARin,    // load mar from bus.
    input  wire              MDRin,    // load mdr.
    input  wire              memRead,  // mdr source is ram, not bus.
    input  wire              memWrite, // mdr into ram at mar.
    output miniSrcPkg::wordT mdrOut
);

    miniSrcPkg::wordT marReg;               // full word, low bits address ram.
    miniSrcPkg::wordT mdrReg;
    miniSrcPkg::addrT memAddr;
    miniSrcPkg::wordT ram [miniSrcPkg::memDepth]; // 512 words.

    initial begin
        $readmemh("program.hex", ram); // program image.
    end

    assign memAddr = marReg[$bits(miniSrcPkg::addrT)-1:0]; // low nine bits.

    always_ff @(posedge clock) begin
        if (!rstN) begin
            marReg <= '0;
        end else if (MARin) begin
            marReg <= busData;
        end
    end

    always_ff @(posedge clock) begin
        if (!rstN) begin
            mdrReg <= '0;
        end else if (MDRin) begin
            if (memRead) begin
                mdrReg <= ram[memAddr]; // read word at mar.
            end else begin
                mdrReg <= busData;
            end
        end
    end

    // ram contents survive reset.
    always_ff @(posedge clock) begin
        if (memWrite) begin
            ram[memAddr] <= mdrReg; // store takes one edge.
        end
    end

    assign mdrOut = mdrReg;

endmodule

`default_nettype wire

//--- miniSrc.f
miniSrcPkg.sv
busArbiter.sv
registerBank.sv
pcIrRegs.sv
aluUnit.sv
memoryInterface.sv
ioPorts.sv
miniSrcDatapath.sv
datapath_chk.sv
tbClock.sv
miniSrcTb.sv

//--- miniSrcDatapath.sv
`timescale 1ns/1ps
`default_nettype none

module miniSrcDatapath (
    input  wire                clock,
    input  wire                rstN,
    input  miniSrcPkg::wordT   inPortDataIn,
    input  miniSrcPkg::opcodeT opcode,
    input  wire                Gra,
    input  wire                Grb,
    input  wire                Grc,
    input  wire                Rin,
    input  wire                Rout,
    input  wire                BAout,
    input  wire                PCout_en,
    input  wire                IncPC,
    input  wire                PC_en,
    input  wire                IRin,
    input  wire                Yin,
    input  wire                Zin,
    input  wire                Zlowout,
    input  wire                Cout,
    input  wire                MDRout,
    input  wire                MDRin,
    input  wire                MARin,
    input  wire                memRead,
    input  wire                memWrite,
    input  wire                inPort_en,
    input  wire                outPort_en,
    input  wire                inPortOut_en,
    output miniSrcPkg::wordT   outPortData
);

    miniSrcPkg::wordT busData;   // the one internal bus.
    miniSrcPkg::wordT regOut;
    miniSrcPkg::wordT cOut;
    miniSrcPkg::wordT pcOut;
    miniSrcPkg::wordT ir;
    miniSrcPkg::wordT zOut;
    miniSrcPkg::wordT mdrOut;
    miniSrcPkg::wordT inPortOut;

    busArbiter i_busArbiter (
        .regOut(regOut), .pcOut(pcOut), .mdrOut(mdrOut), .zOut(zOut),
        .inPortOut(inPortOut), .cOut(cOut),
        .Rout(Rout), .BAout(BAout), .PCout_en(PCout_en), .MDRout(MDRout),
        .Zlowout(Zlowout), .inPortOut_en(inPortOut_en), .Cout(Cout),
        .busData(busData)
    );

    registerBank i_registerBank (
        .clock(clock), .rstN(rstN), .busData(busData), .ir(ir),
        .Gra(Gra), .Grb(Grb), .Grc(Grc), .Rin(Rin), .BAout(BAout),
        .regOut(regOut), .cOut(cOut)
    );

    pcIrRegs i_pcIrRegs (
        .clock(clock), .rstN(rstN), .busData(busData),
        .PC_en(PC_en), .IRin(IRin), .pcOut(pcOut), .ir(ir)
    );

    aluUnit i_aluUnit (
        .clock(clock), .rstN(rstN), .busData(busData), .opcode(opcode),
        .Yin(Yin), .Zin(Zin), .IncPC(IncPC), .zOut(zOut)
    );

    memoryInterface i_memoryInterface (
        .clock(clock), .rstN(rstN), .busData(busData),
        .MARin(MARin), .MDRin(MDRin), .memRead(memRead), .memWrite(memWrite),
        .mdrOut(mdrOut)
    );

    ioPorts i_ioPorts (
        .clock(clock), .rstN(rstN), .busData(busData),
        .inPortDataIn(inPortDataIn), .inPort_en(inPort_en), .outPort_en(outPort_en),
        .inPortOut(inPortOut), .outPortData(outPortData)
    );

endmodule

`default_nettype wire

//--- miniSrcPkg.sv
`default_nettype none

package miniSrcPkg;

    localparam int wordWidth  = 32;   // datapath word.
    localparam int regCount   = 16;   // general registers r0..r15.
    localparam int memDepth   = 512;  // ram words.
    localparam int shamtWidth = 5;    // shift count bits taken from the bus.

    typedef logic [wordWidth-1:0] wordT;   // bus, registers, port data.
    typedef logic [3:0]           regIdxT; // register number.
    typedef logic [4:0]           opcodeT; // alu opcode field.
    typedef logic [8:0]           addrT;   // ram word address.

    // alu opcodes, immediate forms reuse add, and, or.
    localparam opcodeT opAdd = 5'b00011; // also addi.
    localparam opcodeT opSub = 5'b00100;
    localparam opcodeT opShr = 5'b00101; // logical right.
    localparam opcodeT opShl = 5'b00111;
    localparam opcodeT opAnd = 5'b01010; // also andi.
    localparam opcodeT opOr  = 5'b01011; // also ori.
    localparam opcodeT opNeg = 5'b10001;
    localparam opcodeT opNot = 5'b10010;
    localparam opcodeT opNop = 5'b11010; // result is zero.

    // instruction register field positions.
    localparam int raLsb  = 23; // ra in ir[26:23].
    localparam int rbLsb  = 19; // rb in ir[22:19].
    localparam int rcLsb  = 15; // rc in ir[18:15].
    localparam int cWidth = 19; // c in ir[18:0].

endpackage

`default_nettype wire

//--- miniSrcTb.sv
`timescale 1ns/1ps
`default_nettype none

module miniSrcTb;

    localparam int resetLimit = 50; // cycles allowed until reset release.

    logic clock;
    logic rstN;
    miniSrcPkg::wordT inPortDataIn;
    miniSrcPkg::opcodeT opcode;
    logic Gra, Grb, Grc, Rin, Rout, BAout, PCout_en, IncPC, PC_en, IRin, Yin, Zin;
    logic Zlowout, Cout, MDRout, MDRin, MARin, memRead, memWrite;
    logic inPort_en, outPort_en, inPortOut_en;
    miniSrcPkg::wordT outPortData;

    integer seed = 32'haabb2d65; // fixed stimulus seed.
    int checkCount = 0;
    int errorCount = 0;
    int testErrors = 0;          // errors of the running test.

    // first words of program.hex.
    miniSrcPkg::wordT progWords [3] = '{32'h190FFFFB, 32'h51A00F0F, 32'h5AB12345};

    tbClock i_clock (.clock(clock), .rstN(rstN));

    miniSrcDatapath i_dut (.*);

    bind busArbiter datapath_chk i_chk (
        .clock(miniSrcTb.clock), .rstN(miniSrcTb.rstN), .busData(busData), .pcOut(pcOut),
        .Rout(Rout), .BAout(BAout), .PCout_en(PCout_en), .MDRout(MDRout),
        .Zlowout(Zlowout), .inPortOut_en(inPortOut_en), .Cout(Cout)
    );

    task automatic clearStrobes();
        {Gra, Grb, Grc, Rin, Rout, BAout, PCout_en, IncPC, PC_en, IRin, Yin, Zin} = '0;
        {Zlowout, Cout, MDRout, MDRin, MARin, memRead, memWrite} = '0;
        {inPort_en, outPort_en, inPortOut_en} = '0;
    endtask

    // one edge, then strobes drop 2 ns later.
    task automatic nextCycle();
        @(posedge clock);
        #2;
        clearStrobes();
    endtask

    task automatic checkOut(input string what, input miniSrcPkg::wordT expected);
        checkCount++;
        if (outPortData !== expected) begin
            $display("** Error at %0t ns: %s, out port %h, expected %h",
                     $time, what, outPortData, expected);
            errorCount++;
            testErrors++;
        end
    endtask

    task automatic endTest(input string name);
        $display("test %-12s %s, %0d errors", name, (testErrors == 0) ? "ok" : "FAILED",
                 testErrors);
        testErrors = 0;
    endtask

    function automatic miniSrcPkg::wordT aluModel(input miniSrcPkg::opcodeT op,
                                                  input miniSrcPkg::wordT a,
                                                  input miniSrcPkg::wordT b);
        case (op)
            miniSrcPkg::opAdd: return a + b;
            miniSrcPkg::opSub: return a - b;
            miniSrcPkg::opAnd: return a & b;
            miniSrcPkg::opOr:  return a | b;
            miniSrcPkg::opShr: return a >> b[4:0]; // count from low five bits.
            miniSrcPkg::opShl: return a << b[4:0];
            miniSrcPkg::opNeg: return 32'd0 - b;
            miniSrcPkg::opNot: return ~b;
            default:           return '0;         // nop.
        endcase
    endfunction

    function automatic miniSrcPkg::wordT signExtendC(input miniSrcPkg::wordT word);
        return {{13{word[18]}}, word[18:0]};
    endfunction

    task automatic loadInPort(input miniSrcPkg::wordT value);
        inPort_en = 1'b1;
        inPortDataIn = value;
        nextCycle();
    endtask

    // pc to mar and z, z to pc with ram into mdr, mdr to ir.
    task automatic fetch();
        PCout_en = 1'b1;
        MARin = 1'b1;
        IncPC = 1'b1;
        Zin = 1'b1;
        nextCycle();
        Zlowout = 1'b1;
        PC_en = 1'b1;
        memRead = 1'b1;
        MDRin = 1'b1;
        nextCycle();
        MDRout = 1'b1;
        IRin = 1'b1;
        nextCycle();
    endtask

    task automatic clearPc();
        PC_en = 1'b1; // idle bus carries zero.
        nextCycle();
    endtask

    task automatic testReset();
        checkOut("out port after reset", '0);
        PCout_en = 1'b1;
        outPort_en = 1'b1;
        nextCycle();
        checkOut("pc after reset", '0);
        endTest("reset");
    endtask

    task automatic testInToOut();
        miniSrcPkg::wordT value;
        value = $random(seed);
        loadInPort(value);
        inPortOut_en = 1'b1;
        Grb = 1'b1;
        Rin = 1'b1;
        nextCycle();
        Grb = 1'b1;
        Rout = 1'b1;
        outPort_en = 1'b1;
        nextCycle();
        checkOut("in port to reg to out", value);
        Grc = 1'b1;
        BAout = 1'b1;      // r0 still holds the input value.
        outPort_en = 1'b1;
        nextCycle();
        checkOut("base address r0 reads zero", '0);
        endTest("inToOut");
    endtask

    task automatic testImmediate();
        miniSrcPkg::wordT rbValue;
        miniSrcPkg::opcodeT op;
        clearPc();
        for (int i = 0; i < 3; i++) begin
            fetch();
            rbValue = $random(seed);
            op = progWords[i][31:27];
            loadInPort(rbValue);
            inPortOut_en = 1'b1;
            Grb = 1'b1;
            Rin = 1'b1;
            nextCycle();
            Grb = 1'b1;
            Rout = 1'b1;
            Yin = 1'b1;
            nextCycle();
            Cout = 1'b1;
            opcode = op;
            Zin = 1'b1;
            nextCycle();
            Zlowout = 1'b1;
            Gra = 1'b1;
            Rin = 1'b1;
            nextCycle();
            Gra = 1'b1;
            Rout = 1'b1;
            outPort_en = 1'b1;
            nextCycle();
            checkOut($sformatf("immediate word %0d", i),
                     aluModel(op, rbValue, signExtendC(progWords[i])));
        end
        endTest("immediate");
    endtask

    task automatic testAluOps();
        miniSrcPkg::opcodeT ops [9] = '{miniSrcPkg::opAdd, miniSrcPkg::opSub,
            miniSrcPkg::opAnd, miniSrcPkg::opOr, miniSrcPkg::opShr, miniSrcPkg::opShl,
            miniSrcPkg::opNeg, miniSrcPkg::opNot, miniSrcPkg::opNop};
        miniSrcPkg::wordT a;
        miniSrcPkg::wordT b;
        foreach (ops[i]) begin
            a = $random(seed);
            b = $random(seed);
            loadInPort(a);
            inPortOut_en = 1'b1; // a into y while b enters the port.
            Yin = 1'b1;
            inPort_en = 1'b1;
            inPortDataIn = b;
            nextCycle();
            inPortOut_en = 1'b1;
            opcode = ops[i];
            Zin = 1'b1;
            nextCycle();
            Zlowout = 1'b1;
            outPort_en = 1'b1;
            nextCycle();
            checkOut($sformatf("alu opcode %b", ops[i]), aluModel(ops[i], a, b));
        end
        endTest("aluOps");
    endtask

    task automatic testStoreLoad();
        miniSrcPkg::wordT data;
        miniSrcPkg::wordT addr;
        data = $random(seed);
        addr = 16 + ({$random(seed)} % 496); // above the program words.
        loadInPort(addr);
        inPortOut_en = 1'b1;
        MARin = 1'b1;
        inPort_en = 1'b1;
        inPortDataIn = data;
        nextCycle();
        inPortOut_en = 1'b1;
        MDRin = 1'b1;
        nextCycle();
        memWrite = 1'b1;
        nextCycle();
        MDRin = 1'b1; // mdr cleared from idle bus.
        nextCycle();
        MDRin = 1'b1;
        memRead = 1'b1;
        nextCycle();
        MDRout = 1'b1;
        outPort_en = 1'b1;
        nextCycle();
        checkOut($sformatf("load from %0d", addr), data);
        endTest("storeLoad");
    endtask

    task automatic testPcIncrement();
        int fetches;
        fetches = 2 + ({$random(seed)} % 4);
        clearPc();
        repeat (fetches) fetch();
        PCout_en = 1'b1;
        outPort_en = 1'b1;
        nextCycle();
        checkOut($sformatf("pc after %0d fetches", fetches), fetches);
        endTest("pcIncrement");
    endtask

    initial begin
        int waited;
        clearStrobes();
        inPortDataIn = '0;
        opcode = miniSrcPkg::opNop;
        waited = 0;
        while (rstN !== 1'b1 && waited < resetLimit) begin
            @(posedge clock);
            waited++;
        end
        if (rstN !== 1'b1) begin
            $display("timeout, reset was never released");
            $display("Checks failed");
            $finish;
        end else begin
            #2;
            testReset();
            testInToOut();
            testImmediate();
            testAluOps();
            testStoreLoad();
            testPcIncrement();
            $display("%0d checks, %0d errors", checkCount, errorCount);
            if (errorCount == 0) begin
                $display("All checks passed");
            end else begin
                $display("Checks failed");
            end
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- pcIrRegs.sv
`timescale 1ns/1ps
`default_nettype none

module pcIrRegs (
    input  wire              clock,
    input  wire              rstN,
    input  miniSrcPkg::wordT busData,
    input  wire              PC_en,   // load pc from bus.
    input  wire              IRin,    // load ir from bus.
    output miniSrcPkg::wordT pcOut,
    output miniSrcPkg::wordT ir
);

    miniSrcPkg::wordT pcReg; // program counter.
    miniSrcPkg::wordT irReg; // current instruction.

    always_ff @(posedge clock) begin
        if (!rstN) begin
            pcReg <= '0; // fetch starts at word 0.
        end else if (PC_en) begin
            pcReg <= busData; // usually z after increment.
        end
    end

    always_ff @(posedge clock) begin
        if (!rstN) begin
            irReg <= '0;
        end else if (IRin) begin
            irReg <= busData; // from mdr during fetch.
        end
    end

    assign pcOut = pcReg;
    assign ir    = irReg;

endmodule

`default_nettype wire

//--- program.hex
// one 32-bit instruction word per line, from ram address 0.
// fields: opcode[31:27] ra[26:23] rb[22:19] c[18:0]
190FFFFB
51A00F0F
5AB12345
D0000000
D0000000
D0000000

//--- registerBank.sv
`timescale 1ns/1ps
`default_nettype none

module registerBank (
    input  wire              clock,
    input  wire              rstN,
    input  miniSrcPkg::wordT busData,
    input  miniSrcPkg::wordT ir,      // instruction register.
    input  wire              Gra,     // select ra field.
    input  wire              Grb,     // select rb field.
    input  wire              Grc,     // select rc field.
    input  wire              Rin,     // write bus into selected reg.
    input  wire              BAout,   // base-address read, r0 gives zero.
    output miniSrcPkg::wordT regOut,
    output miniSrcPkg::wordT cOut     // sign-extended c field.
);

    miniSrcPkg::wordT  regFile [miniSrcPkg::regCount]; // r0..r15.
    miniSrcPkg::regIdxT raIdx;
    miniSrcPkg::regIdxT rbIdx;
    miniSrcPkg::regIdxT rcIdx;
    miniSrcPkg::regIdxT selIdx;       // decoded register number.

    assign raIdx = ir[miniSrcPkg::raLsb +: 4];
    assign rbIdx = ir[miniSrcPkg::rbLsb +: 4];
    assign rcIdx = ir[miniSrcPkg::rcLsb +: 4];

    // select strobes gate their field, then or together.
    assign selIdx = ({4{Gra}} & raIdx)
                  | ({4{Grb}} & rbIdx)
                  | ({4{Grc}} & rcIdx);

    always_ff @(posedge clock) begin
        if (!rstN) begin
            for (int i = 0; i < miniSrcPkg::regCount; i++) begin
                regFile[i] <= '0; // all registers cleared.
            end
        end else if (Rin) begin
            regFile[selIdx] <= busData; // load from bus.
        end
    end

    // r0 reads as zero only under BAout.
    assign regOut = (BAout && (selIdx == '0)) ? '0 : regFile[selIdx];

    // replicate bit 18 into the upper bits.
    assign cOut = {{(miniSrcPkg::wordWidth - miniSrcPkg::cWidth){ir[miniSrcPkg::cWidth-1]}},
                   ir[miniSrcPkg::cWidth-1:0]};

endmodule

`default_nettype wire

//--- run.sh
#!/bin/sh
# Builds and runs the miniSrc datapath testbench with Verilator.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
    --top-module miniSrcTb -f miniSrc.f -o miniSrcSim

# A failing run may exit non-zero; the search below decides the result.
simOutput=$(./obj_dir/miniSrcSim) || true
echo "$simOutput"

if echo "$simOutput" | grep -q "All checks passed"; then
    exit 0
fi
exit 1

//--- tbClock.sv
`timescale 1ns/1ps
`default_nettype none

module tbClock (
    output logic clock,
    output logic rstN
);

    initial begin
        clock = 1'b0;
        forever #20 clock = ~clock; // 40 ns period.
    end

    initial begin
        rstN = 1'b0;
        repeat (5) @(posedge clock); // held low for five cycles.
        #2;
        rstN = 1'b1;                 // released off the edge.
    end

endmodule

`default_nettype wire
